// File: verilog/nbtSram_defs.svh
/*
 * width and size constants for the NBT SRAM core
 * address, lane and word widths, burst counter, array depth
 */

`ifndef NBT_SRAM_DEFS_SVH
`define NBT_SRAM_DEFS_SVH

// --------------------
// address and array
// --------------------
`define NBT_ADDR_W   10     // word address bits
`define NBT_DEPTH    1024   // words in the array, 2**NBT_ADDR_W

// --------------------
// data word
// --------------------
`define NBT_LANE_W   9      // 8 data + 1 parity, stored as is
`define NBT_LANES    4      // byte lanes a..d
`define NBT_WORD_W   36     // NBT_LANE_W * NBT_LANES

// --------------------
// burst
// --------------------
`define NBT_BURST_W  2      // beat counter, 4-beat bursts

`endif

// File: verilog/nbtSramPkg.sv
/*
 * shared types for the NBT SRAM core
 * lane, lane array, two-view word union, burst FSM states
 */

`include "nbtSram_defs.svh"

package nbtSramPkg;

   // --------------------
   // data word views
   // --------------------

   // one byte lane, parity bit is the msb
   typedef logic [`NBT_LANE_W-1:0] byteLane_t;

   // lane 0 sits in the low bits, same as bwN[0]
   typedef byteLane_t [`NBT_LANES-1:0] laneArray_t;

   // whole word as seen on the data pins, or split per lane
   // for byte-enabled writes
   typedef union packed {
      logic [`NBT_WORD_W-1:0] flat;   // bus view
      laneArray_t             lanes;  // per-lane view
   } sramWord_u;

   // --------------------
   // command FSM
   // --------------------

   // no suspend state here, clock enable is gone
   typedef enum logic [1:0] {
      deselect = 2'd0,   // chip not selected, or idle
      newCycle = 2'd1,   // fresh command loaded
      burst    = 2'd2    // advancing through beats
   } burstState_e;

endpackage

// File: verilog/nbtCommandDecode.sv
/*
 * stage one of the NBT SRAM core
 * select merge, command decode, burst FSM and address order,
 * plus the one-cycle delay that lines commands up with write data
 */

`include "nbtSram_defs.svh"

module nbtCommandDecode (
   input  logic                   CLK,
   input  logic                   reset,
   input  logic [`NBT_ADDR_W-1:0] address,
   input  logic                   ceN,
   input  logic                   ce2,
   input  logic                   ce2N,
   input  logic                   weN,
   input  logic [`NBT_LANES-1:0]  bwN,
   input  logic                   adv,
   input  logic                   burstMode,
   output logic [`NBT_ADDR_W-1:0] opAddress,
   output logic                   opWrite,
   output logic                   opRead,
   output logic [`NBT_LANES-1:0]  opByteEn
);

   // --------------------
   // pin decode
   // --------------------
   logic                  selected;   // all three selects true
   logic                  anyLane;    // at least one lane enabled
   logic                  cmdWrite;   // real write
   logic                  cmdRead;    // read, lanes don't care
   logic [`NBT_LANES-1:0] laneIn;     // active-high lane enables

   assign selected = ~ceN & ce2 & ~ce2N;
   assign laneIn   = ~bwN;
   assign anyLane  = |laneIn;
   assign cmdWrite = ~weN & anyLane;
   assign cmdRead  = weN;
   // ~weN with no lanes falls through as a no-op

   // --------------------
   // command stage registers
   // --------------------
   nbtSramPkg::burstState_e state;
   logic [`NBT_ADDR_W-1:0]  baseAddr;     // address of the loaded command
   logic [`NBT_BURST_W-1:0] beatCnt;      // beat within burst
   logic                    kindWrite;    // current beat is a write
   logic                    kindRead;     // current beat is a read
   logic                    interleaved;  // order latched with the command
   logic [`NBT_LANES-1:0]   laneEn;       // lanes for the current beat
   logic                    canContinue;

   // a burst only follows a real read or write
   assign canContinue = (state != nbtSramPkg::deselect) & (kindWrite | kindRead);

   always_ff @(posedge CLK) begin
      if (reset) begin
         state     <= nbtSramPkg::deselect;
         beatCnt   <= '0;
         kindWrite <= 1'b0;
         kindRead  <= 1'b0;
      end else if (!adv) begin
         if (selected) begin              // load new command
            state     <= nbtSramPkg::newCycle;
            beatCnt   <= '0;
            kindWrite <= cmdWrite;
            kindRead  <= cmdRead;
         end else begin                   // deselect cycle
            state     <= nbtSramPkg::deselect;
            beatCnt   <= '0;
            kindWrite <= 1'b0;
            kindRead  <= 1'b0;
         end
      end else if (canContinue) begin
         state   <= nbtSramPkg::burst;
         beatCnt <= beatCnt + 1'b1;       // wraps after 4 beats
      end
      // adv with nothing to continue holds everything
   end

   // payload of the command stage
   always_ff @(posedge CLK) begin
      if (!adv && selected) begin
         baseAddr    <= address;
         interleaved <= burstMode;
         laneEn      <= laneIn;
      end else if (adv && canContinue && kindWrite) begin
         laneEn <= laneIn;                // fresh lanes every write beat
      end
   end

   // --------------------
   // burst address order
   // --------------------
   logic [`NBT_BURST_W-1:0] beatLow;
   logic [`NBT_ADDR_W-1:0]  beatAddr;

   always_comb begin
      if (interleaved)
         beatLow = baseAddr[`NBT_BURST_W-1:0] ^ beatCnt;   // 1,0,3,2 from 1
      else
         beatLow = baseAddr[`NBT_BURST_W-1:0] + beatCnt;   // mod 4 wrap
   end

   assign beatAddr = {baseAddr[`NBT_ADDR_W-1:`NBT_BURST_W], beatLow};

   // --------------------
   // delay stage to the array
   // --------------------
   always_ff @(posedge CLK) begin
      if (reset) begin
         opWrite <= 1'b0;
         opRead  <= 1'b0;
      end else begin
         opWrite <= kindWrite & (|laneEn);  // burst beat with no lanes is a no-op
         opRead  <= kindRead;
      end
   end

   always_ff @(posedge CLK) begin
      opAddress <= beatAddr;
      opByteEn  <= laneEn;
   end

   // --------------------
   // checks
   // --------------------
   opExclusive: assert property (@(posedge CLK) disable iff (reset)
      !(opWrite && opRead))
      else $error("opWrite and opRead high together");

   idleCounter: assert property (@(posedge CLK) disable iff (reset)
      (state == nbtSramPkg::deselect) |-> (beatCnt == '0))
      else $error("beat counter not cleared in deselect");

endmodule

// File: verilog/nbtByteArray.sv
/*
 * stage two of the NBT SRAM core
 * byte-lane memory, lane-masked writes, registered read port
 */

`include "nbtSram_defs.svh"

module nbtByteArray (
   input  logic                   CLK,
   input  logic                   reset,
   input  logic [`NBT_ADDR_W-1:0] opAddress,
   input  logic                   opWrite,
   input  logic                   opRead,
   input  logic [`NBT_LANES-1:0]  opByteEn,
   input  logic [`NBT_WORD_W-1:0] dataIn,
   output logic [`NBT_WORD_W-1:0] dataOut,
   output logic                   dataOutValid
);

   // --------------------
   // storage
   // --------------------
   nbtSramPkg::sramWord_u mem [`NBT_DEPTH];   // contents undefined until written

   // write data arrives on the same edge the array acts on,
   // two cycles after its command
   nbtSramPkg::sramWord_u wrWord;

   assign wrWord.flat = dataIn;

   // --------------------
   // write port
   // --------------------
   always_ff @(posedge CLK) begin
      if (opWrite) begin
         for (int lane = 0; lane < `NBT_LANES; lane++) begin
            if (opByteEn[lane])
               mem[opAddress].lanes[lane] <= wrWord.lanes[lane];   // untouched lanes keep old value
         end
      end
   end

   // --------------------
   // read port
   // --------------------

   // read and write never share a cycle, so a read one cycle
   // after a write already sees the new word
   always_ff @(posedge CLK) begin
      if (opRead)
         dataOut <= mem[opAddress].flat;   // holds last word otherwise
   end

   always_ff @(posedge CLK) begin
      if (reset)
         dataOutValid <= 1'b0;
      else
         dataOutValid <= opRead;   // one pulse per read beat
   end

   // --------------------
   // checks
   // --------------------

   // stage one must filter out no-lane writes, including burst beats
   noEmptyWrite: assert property (@(posedge CLK) disable iff (reset)
      opWrite |-> (|opByteEn))
      else $error("write issued with no byte lanes enabled");

endmodule

// File: verilog/nbtSram.sv
/*
 * top level of the NBT SRAM core
 * command decode stage feeding the byte-lane array
 */

`include "nbtSram_defs.svh"

module nbtSram (
   input  logic                   CLK,
   input  logic                   reset,
   input  logic [`NBT_ADDR_W-1:0] address,
   input  logic                   ceN,        // select, active low
   input  logic                   ce2,        // select, active high
   input  logic                   ce2N,       // select, active low
   input  logic                   weN,        // low = write
   input  logic [`NBT_LANES-1:0]  bwN,        // lane enables, active low
   input  logic                   adv,        // high continues burst
   input  logic                   burstMode,  // high = interleaved
   input  logic [`NBT_WORD_W-1:0] dataIn,     // two cycles after the write command
   output logic [`NBT_WORD_W-1:0] dataOut,
   output logic                   dataOutValid
);

   // --------------------
   // stage one to stage two
   // --------------------
   logic [`NBT_ADDR_W-1:0] opAddress;
   logic                   opWrite;
   logic                   opRead;
   logic [`NBT_LANES-1:0]  opByteEn;

   nbtCommandDecode nbtCommandDecode_i (
      .CLK       (CLK),
      .reset     (reset),
      .address   (address),
      .ceN       (ceN),
      .ce2       (ce2),
      .ce2N      (ce2N),
      .weN       (weN),
      .bwN       (bwN),
      .adv       (adv),
      .burstMode (burstMode),
      .opAddress (opAddress),
      .opWrite   (opWrite),
      .opRead    (opRead),
      .opByteEn  (opByteEn)
   );

   nbtByteArray nbtByteArray_i (
      .CLK          (CLK),
      .reset        (reset),
      .opAddress    (opAddress),
      .opWrite      (opWrite),
      .opRead       (opRead),
      .opByteEn     (opByteEn),
      .dataIn       (dataIn),
      .dataOut      (dataOut),
      .dataOutValid (dataOutValid)
   );

endmodule

// File: tests/nbtSramTb.sv
/*
 * self-checking testbench for the NBT SRAM core
 * replays command records from the testdata file, delays write data
 * two edges and checks each read word three edges after its command
 */

`include "nbtSram_defs.svh"

module nbtSramTb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MaxLines  = 128;   // record slots
   localparam int RecFields = 7;     // test kind addr lanes mode wdata expect
   localparam int ReadLag   = 4;     // loop passes from driving a read to checking it

   // command kinds in the data file
   localparam int KindIdle      = 0;
   localparam int KindWrite     = 1;
   localparam int KindRead      = 2;
   localparam int KindWriteBeat = 3;
   localparam int KindReadBeat  = 4;
   localparam int KindNoLanes   = 5;   // selected write, all lanes off
   localparam int KindDeselWr   = 6;   // write with ce2N high

   // --------------------
   // DUT pins
   // --------------------
   logic                   CLK;
   logic                   reset;
   logic [`NBT_ADDR_W-1:0] address;
   logic                   ceN;
   logic                   ce2;
   logic                   ce2N;
   logic                   weN;
   logic [`NBT_LANES-1:0]  bwN;
   logic                   adv;
   logic                   burstMode;
   logic [`NBT_WORD_W-1:0] dataIn;
   logic [`NBT_WORD_W-1:0] dataOut;
   logic                   dataOutValid;

   // --------------------
   // vectors and scoreboard
   // --------------------
   logic [`NBT_WORD_W-1:0] vecMem [0:RecFields*MaxLines-1];
   int                     lineCount;
   bit                     vectorsLoaded;

   logic [`NBT_WORD_W-1:0] wrDataQ [$];    // write data waiting for its edge
   bit                     expValidQ [$];  // one slot per cycle
   logic [`NBT_WORD_W-1:0] expWordQ [$];
   int                     expTestQ [$];   // test the slot belongs to

   int errorCount;
   int testErrors;
   int curTest;
   int testsRun;
   int testsPassed;

   nbtSram nbtSram_i (
      .CLK          (CLK),
      .reset        (reset),
      .address      (address),
      .ceN          (ceN),
      .ce2          (ce2),
      .ce2N         (ce2N),
      .weN          (weN),
      .bwN          (bwN),
      .adv          (adv),
      .burstMode    (burstMode),
      .dataIn       (dataIn),
      .dataOut      (dataOut),
      .dataOutValid (dataOutValid)
   );

   always #50 CLK = ~CLK;   // 100 ns period

   // --------------------
   // checks and reporting
   // --------------------
   task automatic checkValue(input string name, input logic [`NBT_WORD_W-1:0] actual,
                             input logic [`NBT_WORD_W-1:0] expected);
      if (actual !== expected) begin
         $display("** Error: test %0d, %s is %h, expected %h", curTest, name, actual, expected);
         errorCount++;
         testErrors++;
      end
   endtask

   task automatic reportFailure(input string what);
      $display("test %0d: %s", curTest, what);   // failure with no value to show
      errorCount++;
      testErrors++;
   endtask

   task automatic finishTest();
      testsRun++;
      if (testErrors == 0) begin
         testsPassed++;
         $display("test %0d: pass", curTest);
      end else begin
         $display("test %0d: fail, %0d errors", curTest, testErrors);
      end
   endtask

   // slot for the read driven ReadLag passes ago, sampled before this edge's updates
   task automatic checkReadSlot();
      bit                     expValid;
      logic [`NBT_WORD_W-1:0] expWord;
      int                     expTest;
      expValid = expValidQ.pop_front();
      expWord  = expWordQ.pop_front();
      expTest  = expTestQ.pop_front();
      if (expTest != curTest) begin   // previous test fully checked
         finishTest();
         curTest    = expTest;
         testErrors = 0;
      end
      if (expValid) begin
         if (dataOutValid !== 1'b1)
            reportFailure("read data expected but dataOutValid is low");
         else
            checkValue("dataOut", dataOut, expWord);
      end else if (dataOutValid !== 1'b0) begin
         reportFailure("dataOutValid high with no read pending");
      end
   endtask

   task automatic pushSlot(input bit valid, input logic [`NBT_WORD_W-1:0] word, input int test);
      expValidQ.push_back(valid);
      expWordQ.push_back(word);
      expTestQ.push_back(test);
   endtask

   // --------------------
   // stimulus
   // --------------------
   task automatic driveCommand(input int kind, input logic [`NBT_ADDR_W-1:0] addr,
                               input logic [`NBT_LANES-1:0] lanes, input logic mode);
      logic                  ceNv;
      logic                  ce2Nv;
      logic                  weNv;
      logic                  advv;
      logic [`NBT_LANES-1:0] bwv;
      ceNv  = 1'b1;   // deselected unless the kind says so
      ce2Nv = 1'b0;
      weNv  = 1'b1;
      advv  = 1'b0;
      bwv   = '1;
      case (kind)
         KindWrite: begin
            ceNv = 1'b0;
            weNv = 1'b0;
            bwv  = ~lanes;
         end
         KindRead:  ceNv = 1'b0;
         KindWriteBeat: begin
            ceNv = 1'b0;
            advv = 1'b1;
            bwv  = ~lanes;   // fresh lanes per beat
         end
         KindReadBeat: begin
            ceNv = 1'b0;
            advv = 1'b1;
         end
         KindNoLanes: begin
            ceNv = 1'b0;
            weNv = 1'b0;     // bwN stays all high
         end
         KindDeselWr: begin
            ceNv  = 1'b0;
            ce2Nv = 1'b1;    // one select off is enough
            weNv  = 1'b0;
            bwv   = ~lanes;
         end
         default: ;          // idle
      endcase
      ceN       <= ceNv;
      ce2       <= 1'b1;
      ce2N      <= ce2Nv;
      weN       <= weNv;
      bwN       <= bwv;
      adv       <= advv;
      address   <= addr;
      burstMode <= mode;
   endtask

   // data of the command driven two passes ago, so it sits on dataIn at edge N+2
   task automatic applyWriteData(input logic [`NBT_WORD_W-1:0] value);
      wrDataQ.push_back(value);
      if (wrDataQ.size() > 2)
         dataIn <= wrDataQ.pop_front();
   endtask

   task automatic loadVectors();
      int base;
      bit done;
      $readmemh("tests/nbtSram_testdata.txt", vecMem);
      lineCount = 0;
      done      = 1'b0;
      while (!done && lineCount < MaxLines) begin
         base = lineCount * RecFields;
         // test number 0, ff or unknown ends the list
         if ($isunknown(vecMem[base]) || vecMem[base] == 0 || vecMem[base] == 'hff)
            done = 1'b1;
         else
            lineCount++;
      end
   endtask

   task automatic applyReset();
      for (int cycle = 0; cycle < 3; cycle++) begin
         @(posedge CLK);
         if (cycle > 0 && dataOutValid !== 1'b0)   // first edge clears it
            reportFailure("dataOutValid high during reset");
      end
      reset <= 1'b0;
   endtask

   task automatic runVectors();
      int base;
      int kind;
      int lastTest;
      repeat (ReadLag) pushSlot(1'b0, '0, curTest);   // nothing expected yet
      for (int line = 0; line < lineCount; line++) begin
         base = line * RecFields;
         kind = int'(vecMem[base+1]);
         @(posedge CLK);
         checkReadSlot();
         driveCommand(kind, vecMem[base+2][`NBT_ADDR_W-1:0], vecMem[base+3][`NBT_LANES-1:0],
                      vecMem[base+4][0]);
         applyWriteData(vecMem[base+5]);
         pushSlot(kind == KindRead || kind == KindReadBeat, vecMem[base+6], int'(vecMem[base]));
      end
      lastTest = int'(vecMem[(lineCount-1)*RecFields]);
      repeat (ReadLag) begin   // drain reads still in flight
         @(posedge CLK);
         checkReadSlot();
         driveCommand(KindIdle, '0, '0, 1'b0);
         applyWriteData('0);
         pushSlot(1'b0, '0, lastTest);
      end
      finishTest();
   endtask

   // --------------------
   // main flow
   // --------------------
   initial begin
      CLK         = 1'b0;
      reset       = 1'b1;
      address     = '0;
      ceN         = 1'b1;
      ce2         = 1'b0;
      ce2N        = 1'b1;
      weN         = 1'b1;
      bwN         = '1;
      adv         = 1'b0;
      burstMode   = 1'b0;
      dataIn      = '0;
      errorCount  = 0;
      testErrors  = 0;
      testsRun    = 0;
      testsPassed = 0;
      loadVectors();
      vectorsLoaded = 1'b1;
      if (lineCount == 0) begin
         $display("no usable records in tests/nbtSram_testdata.txt");
         errorCount++;
      end else begin
         curTest = int'(vecMem[0]);   // reset checks count toward the first test
         applyReset();
         runVectors();
      end
      $display("%0d tests run, %0d passed, %0d errors", testsRun, testsPassed, errorCount);
      if (errorCount == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // watchdog, scaled to the number of records
   initial begin
      wait (vectorsLoaded);
      #((lineCount + 20) * 100);
      $display("watchdog expired after %0d ns, run did not complete", (lineCount + 20) * 100);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: tests/nbtSram_testdata.txt
// test kind addr lanes mode wdata expect, all hex, one command per clock
// kind 0 idle, 1 write, 2 read, 3 write beat, 4 read beat,
// 5 write with no lanes, 6 write while deselected (ce2N high)

// reset and idle
01 0 000 0 0 000000000 000000000
01 0 000 0 0 000000000 000000000
01 0 3ff 0 0 000000000 000000000
01 0 000 0 0 000000000 000000000

// single write and read back, read in the very next cycle
02 1 005 f 0 123456789 000000000
02 2 005 0 0 000000000 123456789
02 1 006 f 0 abcdef012 000000000
02 2 006 0 0 000000000 abcdef012
02 2 005 0 0 000000000 123456789
02 0 000 0 0 000000000 000000000

// byte-lane merge, lane n is bits 9n+8..9n
03 1 040 f 0 000000000 000000000
03 1 040 2 0 fffffffff 000000000
03 1 040 8 0 fffffffff 000000000
03 2 040 0 0 000000000 ff803fe00
03 1 041 f 0 fffffffff 000000000
03 1 041 1 0 000000000 000000000
03 1 041 8 0 000000000 000000000
03 2 041 0 0 000000000 007fffe00
03 1 042 f 0 000000000 000000000
03 1 042 5 0 fffffffff 000000000
03 2 042 0 0 000000000 007fc01ff
03 0 000 0 0 000000000 000000000

// linear burst from low bits 2, beats at 2 3 0 1, fifth read beat wraps
04 1 012 f 0 111111111 000000000
04 3 013 f 0 222222222 000000000
04 3 010 f 0 333333333 000000000
04 3 011 f 0 444444444 000000000
04 0 000 0 0 000000000 000000000
04 2 012 0 0 000000000 111111111
04 4 013 0 0 000000000 222222222
04 4 010 0 0 000000000 333333333
04 4 011 0 0 000000000 444444444
04 4 012 0 0 000000000 111111111
04 2 010 0 0 000000000 333333333
04 2 013 0 0 000000000 222222222
04 0 000 0 0 000000000 000000000

// interleaved burst from low bits 1, beats at 1 0 3 2
05 1 021 f 1 555555555 000000000
05 3 020 f 1 666666666 000000000
05 3 023 f 1 777777777 000000000
05 3 022 f 1 888888888 000000000
05 0 000 0 0 000000000 000000000
05 2 020 0 0 000000000 666666666
05 2 021 0 0 000000000 555555555
05 2 022 0 0 000000000 888888888
05 2 023 0 0 000000000 777777777
05 2 021 0 1 000000000 555555555
05 4 020 0 1 000000000 666666666
05 4 023 0 1 000000000 777777777
05 4 022 0 1 000000000 888888888
05 0 000 0 0 000000000 000000000

// no-ops leave memory alone, adv after them does nothing
06 6 005 f 0 fffffffff 000000000
06 3 005 f 0 fffffffff 000000000
06 5 006 0 0 000000000 000000000
06 3 006 f 0 fffffffff 000000000
06 0 000 0 0 000000000 000000000
06 2 005 0 0 000000000 123456789
06 2 006 0 0 000000000 abcdef012
06 0 000 0 0 000000000 000000000
06 0 000 0 0 000000000 000000000

// end of records
ff 0 000 0 0 000000000 000000000

// File: project.f
+incdir+verilog
verilog/nbtSramPkg.sv
verilog/nbtCommandDecode.sv
verilog/nbtByteArray.sv
verilog/nbtSram.sv
tests/nbtSramTb.sv
